/* gpuIssue_consts.svh */
`ifndef GPU_ISSUE_CONSTS_SVH
`define GPU_ISSUE_CONSTS_SVH

// core size
`define NUM_WARPS   4
`define NUM_THREADS 8
`define WARP_ID_W   $clog2(`NUM_WARPS)

// decoded entries held per warp
`define IB_DEPTH    2

// decoded field widths
`define REG_W       5
`define IMM_W       16

`endif

/* gpuIssuePkg.sv */
`default_nettype none

package gpuIssuePkg;

    // operation carried from decode to the operand collector
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        MUL  = 4'd7,
        LW   = 4'd8,
        SW   = 4'd9,
        BEQ  = 4'd10,
        BLT  = 4'd11,
        EXIT = 4'd12,
        NOP  = 4'd13
    } aluOpT;

    // state of one warp buffer
    typedef enum logic [1:0] {
        IDLE,
        READY,
        REPLAYWAIT,
        EXITED
    } wbStateT;

endpackage

`default_nettype wire

/* warpInstBuffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gpuIssue_consts.svh"

module warpInstBuffer (
    input  wire                        clk,
    input  wire                        rstN,
    // decode side
    input  wire                        decValid,
    input  wire gpuIssuePkg::aluOpT    decAluOp,
    input  wire [`REG_W-1:0]           decDst,
    input  wire [`REG_W-1:0]           decSrc1,
    input  wire [`REG_W-1:0]           decSrc2,
    input  wire                        decSrc1Valid,
    input  wire                        decSrc2Valid,
    input  wire [`IMM_W-1:0]           decImm,
    input  wire                        decImmValid,
    input  wire                        decRegWrite,
    input  wire                        decMemRead,
    input  wire                        decMemWrite,
    input  wire [`NUM_THREADS-1:0]     activeMask,
    output logic                       fetchReq,
    // SIMT stack and scoreboard
    input  wire                        dropInstr,
    input  wire                        scbFull,
    input  wire                        scbDependent,
    output logic                       issueReq,
    output logic                       exitReq,
    input  wire                        issueGrant,
    input  wire                        exitGrant,
    // memory stage feedback
    input  wire                        posFbValid,
    input  wire [`NUM_THREADS-1:0]     posFbMask,
    input  wire                        zeroFbValid,
    // head entry toward the issue mux
    output gpuIssuePkg::aluOpT         headAluOp,
    output logic [`REG_W-1:0]          headDst,
    output logic [`REG_W-1:0]          headSrc1,
    output logic [`REG_W-1:0]          headSrc2,
    output logic                       headSrc1Valid,
    output logic                       headSrc2Valid,
    output logic [`IMM_W-1:0]          headImm,
    output logic                       headImmValid,
    output logic                       headRegWrite,
    output logic                       headMemRead,
    output logic                       headMemWrite,
    output logic [`NUM_THREADS-1:0]    headMask
);
    import gpuIssuePkg::*;

    localparam int PTR_W = $clog2(`IB_DEPTH);
    localparam int CNT_W = $clog2(`IB_DEPTH + 1);

    typedef struct packed {
        aluOpT                   aluOp;
        logic [`REG_W-1:0]       dst;
        logic [`REG_W-1:0]       src1;
        logic [`REG_W-1:0]       src2;
        logic                    src1Valid;
        logic                    src2Valid;
        logic [`IMM_W-1:0]       imm;
        logic                    immValid;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic [`NUM_THREADS-1:0] mask;
    } entryT;

    entryT            entries [`IB_DEPTH];
    entryT            head;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] countNext;
    logic             inFlight;
    wbStateT          state;
    wbStateT          stateNext;
    logic             headValid;
    logic             headIsExit;
    logic             headIsMem;
    logic             push;
    logic             pop;
    logic             retire;
    logic             replay;

    function automatic logic [PTR_W-1:0] ptrInc(input logic [PTR_W-1:0] p);
        ptrInc = (p == PTR_W'(`IB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // head decode and requests
    //////////////////////////////////////////////////

    assign head       = entries[rdPtr];
    assign headValid  = (count != '0);
    assign headIsExit = (head.aluOp == EXIT);
    assign headIsMem  = head.memRead | head.memWrite;

    // feedback only counts while a memory head is outstanding
    assign retire = (state == REPLAYWAIT) && zeroFbValid;
    assign replay = (state == REPLAYWAIT) && posFbValid && !zeroFbValid;

    assign push = decValid && (state != EXITED) && !dropInstr && !exitGrant;
    assign pop  = (issueGrant && !headIsMem) || retire;

    assign countNext = count + CNT_W'(push) - CNT_W'(pop);

    // one slot reserved for a fetch still on its way through decode
    assign fetchReq = (state != EXITED) && ((int'(count) + int'(inFlight)) < `IB_DEPTH);

    assign issueReq = headValid && !headIsExit && (state == READY) && !scbFull && !scbDependent;
    assign exitReq  = headValid && headIsExit && (state == READY);

    //////////////////////////////////////////////////
    // state and pointers
    //////////////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            IDLE, READY: begin
                // memory heads stay put until the memory stage answers
                if (issueGrant && headIsMem)
                    stateNext = REPLAYWAIT;
                else
                    stateNext = (countNext != '0) ? READY : IDLE;
            end
            REPLAYWAIT: begin
                if (retire)
                    stateNext = (countNext != '0) ? READY : IDLE;
                else if (replay)
                    stateNext = READY;
            end
            default: stateNext = state;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            rdPtr    <= '0;
            wrPtr    <= '0;
            count    <= '0;
            inFlight <= 1'b0;
        end else begin
            inFlight <= fetchReq;
            if (exitGrant || dropInstr) begin
                rdPtr <= '0;
                wrPtr <= '0;
                count <= '0;
                if (exitGrant || state == EXITED)
                    state <= EXITED;
                else
                    state <= IDLE;
            end else if (state != EXITED) begin
                if (push)
                    wrPtr <= ptrInc(wrPtr);
                if (pop)
                    rdPtr <= ptrInc(rdPtr);
                count <= countNext;
                state <= stateNext;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= '{aluOp: decAluOp, dst: decDst, src1: decSrc1, src2: decSrc2,
                                src1Valid: decSrc1Valid, src2Valid: decSrc2Valid,
                                imm: decImm, immValid: decImmValid, regWrite: decRegWrite,
                                memRead: decMemRead, memWrite: decMemWrite, mask: activeMask};
        end
        // threads that missed go round again
        if (replay)
            entries[rdPtr].mask <= posFbMask;
    end

    assign headAluOp     = head.aluOp;
    assign headDst       = head.dst;
    assign headSrc1      = head.src1;
    assign headSrc2      = head.src2;
    assign headSrc1Valid = head.src1Valid;
    assign headSrc2Valid = head.src2Valid;
    assign headImm       = head.imm;
    assign headImmValid  = head.immValid;
    assign headRegWrite  = head.regWrite;
    assign headMemRead   = head.memRead;
    assign headMemWrite  = head.memWrite;
    assign headMask      = head.mask;

endmodule

`default_nettype wire

/* instBuffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gpuIssue_consts.svh"

module instBuffer (
    input  wire                                clk,
    input  wire                                rstN,
    // shared decode fields
    input  wire gpuIssuePkg::aluOpT            decAluOp,
    input  wire [`REG_W-1:0]                   decDst,
    input  wire [`REG_W-1:0]                   decSrc1,
    input  wire [`REG_W-1:0]                   decSrc2,
    input  wire                                decSrc1Valid,
    input  wire                                decSrc2Valid,
    input  wire [`IMM_W-1:0]                   decImm,
    input  wire                                decImmValid,
    input  wire                                decRegWrite,
    input  wire                                decMemRead,
    input  wire                                decMemWrite,
    // per-warp controls
    input  wire [`NUM_WARPS-1:0]               decValid,
    input  wire [`NUM_WARPS-1:0]               dropInstr,
    input  wire [`NUM_WARPS*`NUM_THREADS-1:0]  activeMask,
    input  wire [`NUM_WARPS-1:0]               scbFull,
    input  wire [`NUM_WARPS-1:0]               scbDependent,
    output logic [`NUM_WARPS-1:0]              fetchReq,
    output logic [`NUM_WARPS-1:0]              issueReq,
    output logic [`NUM_WARPS-1:0]              exitReq,
    input  wire [`NUM_WARPS-1:0]               issueGrant,
    input  wire [`NUM_WARPS-1:0]               exitGrant,
    // toward the operand collector
    output logic                               issueValid,
    output logic [`WARP_ID_W-1:0]              issueWarpId,
    output gpuIssuePkg::aluOpT                 issueAluOp,
    output logic [`REG_W-1:0]                  issueDst,
    output logic [`REG_W-1:0]                  issueSrc1,
    output logic [`REG_W-1:0]                  issueSrc2,
    output logic                               issueSrc1Valid,
    output logic                               issueSrc2Valid,
    output logic [`IMM_W-1:0]                  issueImm,
    output logic                               issueImmValid,
    output logic                               issueRegWrite,
    output logic                               issueMemRead,
    output logic                               issueMemWrite,
    output logic [`NUM_THREADS-1:0]            issueMask,
    output logic                               exitValid,
    output logic [`WARP_ID_W-1:0]              exitWarpId,
    // memory stage feedback
    input  wire                                posFbValid,
    input  wire [`WARP_ID_W-1:0]               posFbWarpId,
    input  wire [`NUM_THREADS-1:0]             posFbMask,
    input  wire                                zeroFbValid,
    input  wire [`WARP_ID_W-1:0]               zeroFbWarpId
);
    import gpuIssuePkg::*;

    localparam int WID_W = `WARP_ID_W;

    aluOpT                   headAluOp [`NUM_WARPS];
    logic [`REG_W-1:0]       headDst [`NUM_WARPS];
    logic [`REG_W-1:0]       headSrc1 [`NUM_WARPS];
    logic [`REG_W-1:0]       headSrc2 [`NUM_WARPS];
    logic [`IMM_W-1:0]       headImm [`NUM_WARPS];
    logic [`NUM_THREADS-1:0] headMask [`NUM_WARPS];
    logic [`NUM_WARPS-1:0]   headSrc1Valid;
    logic [`NUM_WARPS-1:0]   headSrc2Valid;
    logic [`NUM_WARPS-1:0]   headImmValid;
    logic [`NUM_WARPS-1:0]   headRegWrite;
    logic [`NUM_WARPS-1:0]   headMemRead;
    logic [`NUM_WARPS-1:0]   headMemWrite;
    logic [`NUM_WARPS-1:0]   posFbStrobe;
    logic [`NUM_WARPS-1:0]   zeroFbStrobe;

    // feedback warp id to one strobe per warp
    always_comb begin
        posFbStrobe = '0;
        zeroFbStrobe = '0;
        posFbStrobe[posFbWarpId] = posFbValid;
        zeroFbStrobe[zeroFbWarpId] = zeroFbValid;
    end

    //////////////////////////////////////////////////
    // per-warp buffers
    //////////////////////////////////////////////////

    for (genvar w = 0; w < `NUM_WARPS; w++) begin : gWarp
        warpInstBuffer wb (
            .clk          (clk),
            .rstN         (rstN),
            .decValid     (decValid[w]),
            .decAluOp     (decAluOp),
            .decDst       (decDst),
            .decSrc1      (decSrc1),
            .decSrc2      (decSrc2),
            .decSrc1Valid (decSrc1Valid),
            .decSrc2Valid (decSrc2Valid),
            .decImm       (decImm),
            .decImmValid  (decImmValid),
            .decRegWrite  (decRegWrite),
            .decMemRead   (decMemRead),
            .decMemWrite  (decMemWrite),
            .activeMask   (activeMask[w*`NUM_THREADS +: `NUM_THREADS]),
            .fetchReq     (fetchReq[w]),
            .dropInstr    (dropInstr[w]),
            .scbFull      (scbFull[w]),
            .scbDependent (scbDependent[w]),
            .issueReq     (issueReq[w]),
            .exitReq      (exitReq[w]),
            .issueGrant   (issueGrant[w]),
            .exitGrant    (exitGrant[w]),
            .posFbValid   (posFbStrobe[w]),
            .posFbMask    (posFbMask),
            .zeroFbValid  (zeroFbStrobe[w]),
            .headAluOp    (headAluOp[w]),
            .headDst      (headDst[w]),
            .headSrc1     (headSrc1[w]),
            .headSrc2     (headSrc2[w]),
            .headSrc1Valid(headSrc1Valid[w]),
            .headSrc2Valid(headSrc2Valid[w]),
            .headImm      (headImm[w]),
            .headImmValid (headImmValid[w]),
            .headRegWrite (headRegWrite[w]),
            .headMemRead  (headMemRead[w]),
            .headMemWrite (headMemWrite[w]),
            .headMask     (headMask[w])
        );
    end

    //////////////////////////////////////////////////
    // granted head toward the operand collector
    //////////////////////////////////////////////////

    assign issueValid = |issueGrant;
    assign exitValid  = |exitGrant;

    // grants are one-hot, so at most one warp matches
    always_comb begin
        issueWarpId    = '0;
        exitWarpId     = '0;
        issueAluOp     = NOP;
        issueDst       = '0;
        issueSrc1      = '0;
        issueSrc2      = '0;
        issueSrc1Valid = 1'b0;
        issueSrc2Valid = 1'b0;
        issueImm       = '0;
        issueImmValid  = 1'b0;
        issueRegWrite  = 1'b0;
        issueMemRead   = 1'b0;
        issueMemWrite  = 1'b0;
        issueMask      = '0;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            if (exitGrant[w])
                exitWarpId = WID_W'(w);
            if (issueGrant[w]) begin
                issueWarpId    = WID_W'(w);
                issueAluOp     = headAluOp[w];
                issueDst       = headDst[w];
                issueSrc1      = headSrc1[w];
                issueSrc2      = headSrc2[w];
                issueSrc1Valid = headSrc1Valid[w];
                issueSrc2Valid = headSrc2Valid[w];
                issueImm       = headImm[w];
                issueImmValid  = headImmValid[w];
                issueRegWrite  = headRegWrite[w];
                issueMemRead   = headMemRead[w];
                issueMemWrite  = headMemWrite[w];
                issueMask      = headMask[w];
            end
        end
    end

endmodule

`default_nettype wire

/* issueArbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gpuIssue_consts.svh"

module issueArbiter (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire [`NUM_WARPS-1:0]   issueReq,
    input  wire [`NUM_WARPS-1:0]   exitReq,
    output logic [`NUM_WARPS-1:0]  issueGrant,
    output logic [`NUM_WARPS-1:0]  exitGrant
);
    localparam int WID_W = `WARP_ID_W;

    logic [WID_W-1:0] rrPtr;
    logic [WID_W-1:0] grantIdx;
    logic             granted;

    //////////////////////////////////////////////////
    // round-robin issue grant
    //////////////////////////////////////////////////

    // first requester at or after rrPtr, wrapping
    always_comb begin : rrPick
        int idx;
        issueGrant = '0;
        grantIdx   = '0;
        granted    = 1'b0;
        for (int k = 0; k < `NUM_WARPS; k++) begin
            idx = (int'(rrPtr) + k) % `NUM_WARPS;
            if (!granted && issueReq[idx]) begin
                granted         = 1'b1;
                grantIdx        = WID_W'(idx);
                issueGrant[idx] = 1'b1;
            end
        end
    end

    // pointer moves just past the winner
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            rrPtr <= '0;
        else if (granted)
            rrPtr <= (int'(grantIdx) == `NUM_WARPS - 1) ? '0 : grantIdx + 1'b1;
    end

    // exits take the lowest index, isolated by two's complement
    assign exitGrant = exitReq & (~exitReq + 1'b1);

endmodule

`default_nettype wire

/* issueStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gpuIssue_consts.svh"

module issueStage (
    input  wire                                clk,
    input  wire                                rstN,
    // decode
    input  wire gpuIssuePkg::aluOpT            decAluOp,
    input  wire [`REG_W-1:0]                   decDst,
    input  wire [`REG_W-1:0]                   decSrc1,
    input  wire [`REG_W-1:0]                   decSrc2,
    input  wire                                decSrc1Valid,
    input  wire                                decSrc2Valid,
    input  wire [`IMM_W-1:0]                   decImm,
    input  wire                                decImmValid,
    input  wire                                decRegWrite,
    input  wire                                decMemRead,
    input  wire                                decMemWrite,
    input  wire [`NUM_WARPS-1:0]               decValid,
    // SIMT stack, scoreboard, fetch
    input  wire [`NUM_WARPS-1:0]               dropInstr,
    input  wire [`NUM_WARPS*`NUM_THREADS-1:0]  activeMask,
    input  wire [`NUM_WARPS-1:0]               scbFull,
    input  wire [`NUM_WARPS-1:0]               scbDependent,
    output logic [`NUM_WARPS-1:0]              fetchReq,
    // operand collector
    output logic                               issueValid,
    output logic [`WARP_ID_W-1:0]              issueWarpId,
    output gpuIssuePkg::aluOpT                 issueAluOp,
    output logic [`REG_W-1:0]                  issueDst,
    output logic [`REG_W-1:0]                  issueSrc1,
    output logic [`REG_W-1:0]                  issueSrc2,
    output logic                               issueSrc1Valid,
    output logic                               issueSrc2Valid,
    output logic [`IMM_W-1:0]                  issueImm,
    output logic                               issueImmValid,
    output logic                               issueRegWrite,
    output logic                               issueMemRead,
    output logic                               issueMemWrite,
    output logic [`NUM_THREADS-1:0]            issueMask,
    output logic                               exitValid,
    output logic [`WARP_ID_W-1:0]              exitWarpId,
    // memory stage
    input  wire                                posFbValid,
    input  wire [`WARP_ID_W-1:0]               posFbWarpId,
    input  wire [`NUM_THREADS-1:0]             posFbMask,
    input  wire                                zeroFbValid,
    input  wire [`WARP_ID_W-1:0]               zeroFbWarpId
);
    // request and grant between buffer and arbiter
    logic [`NUM_WARPS-1:0] issueReq;
    logic [`NUM_WARPS-1:0] exitReq;
    logic [`NUM_WARPS-1:0] issueGrant;
    logic [`NUM_WARPS-1:0] exitGrant;

    instBuffer ib (.*);

    issueArbiter arb (.*);

endmodule

`default_nettype wire

/* issueStage_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gpuIssue_consts.svh"

module issueStage_tb;
    import gpuIssuePkg::*;

    typedef struct packed {
        aluOpT                   op;
        logic [`REG_W-1:0]       dst;
        logic [`REG_W-1:0]       src1;
        logic [`REG_W-1:0]       src2;
        logic                    s1v;
        logic                    s2v;
        logic [`IMM_W-1:0]       imm;
        logic                    immv;
        logic                    rw;
        logic                    mr;
        logic                    mw;
        logic [`NUM_THREADS-1:0] mask;
    } instT;

    // instruction k uses warps[2k+:2] and ops[4k+:4]
    // expected issue k uses expW[2k+:2]
    typedef struct {
        string       name;
        int          nInst;
        logic [15:0] warps;
        logic [31:0] ops;
        bit          rnd;
        logic [3:0]  hold;
        int          holdCyc;
        logic [3:0]  drop;
        int          replays;
        logic [7:0]  fbMask;
        int          nExp;
        logic [15:0] expW;
        logic [3:0]  expExit;
    } testT;

    localparam int NT = 5;

    logic clk;
    logic rstN;
    aluOpT decAluOp;
    logic [`REG_W-1:0] decDst, decSrc1, decSrc2;
    logic decSrc1Valid, decSrc2Valid, decImmValid, decRegWrite, decMemRead, decMemWrite;
    logic [`IMM_W-1:0] decImm;
    logic [`NUM_WARPS-1:0] decValid, dropInstr, scbFull, scbDependent, fetchReq;
    logic [`NUM_WARPS*`NUM_THREADS-1:0] activeMask;
    logic issueValid, issueSrc1Valid, issueSrc2Valid, issueImmValid;
    logic issueRegWrite, issueMemRead, issueMemWrite, exitValid;
    logic [`WARP_ID_W-1:0] issueWarpId, exitWarpId, posFbWarpId, zeroFbWarpId;
    aluOpT issueAluOp;
    logic [`REG_W-1:0] issueDst, issueSrc1, issueSrc2;
    logic [`IMM_W-1:0] issueImm;
    logic [`NUM_THREADS-1:0] issueMask, posFbMask;
    logic posFbValid, zeroFbValid;

    issueStage uut (.*);

    testT tests [NT];
    string curName;
    int testErrors, totalErrors, passed, cycles, limit;
    // reference model of the per-warp queues
    instT mEnt [`NUM_WARPS][2];
    int mCnt [`NUM_WARPS];
    bit mWait [`NUM_WARPS];
    bit mExited [`NUM_WARPS];
    int rrPtr;
    int obsWarps [$];
    logic [`NUM_WARPS-1:0] obsExit;
    int fbLeft;
    logic [`WARP_ID_W-1:0] fbWarp;
    logic [`NUM_THREADS-1:0] fbMaskCur;
    bit fbPending;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("run timed out after %0d cycles, DUT stopped making progress", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic expectEq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("FAILED %s %s: expected %h actual %h", curName, what, exp, act);
            testErrors++;
        end
    endtask

    function automatic bit isMem(input instT i);
        isMem = i.mr | i.mw;
    endfunction

    //////////////////////////////////////////////////
    // lockstep check, model update, next falling edge
    //////////////////////////////////////////////////

    task automatic stepCycle();
        logic [`NUM_WARPS-1:0] eIssue;
        logic [`NUM_WARPS-1:0] eExit;
        logic [`NUM_WARPS-1:0] req;
        instT act;
        instT hd;
        bit popIt;
        int w;
        #1;
        eIssue = '0;
        eExit = '0;
        for (int k = 0; k < `NUM_WARPS; k++) begin
            req[k] = mCnt[k] > 0 && mEnt[k][0].op != EXIT && !mWait[k] && !mExited[k]
                     && !scbFull[k] && !scbDependent[k];
            if (mCnt[k] > 0 && mEnt[k][0].op == EXIT && !mWait[k] && eExit == '0)
                eExit[k] = 1'b1;
        end
        for (int k = 0; k < `NUM_WARPS; k++) begin
            w = (rrPtr + k) % `NUM_WARPS;
            if (eIssue == '0 && req[w])
                eIssue[w] = 1'b1;
        end
        expectEq("issueValid", 64'(|eIssue), 64'(issueValid));
        expectEq("exitValid", 64'(|eExit), 64'(exitValid));
        act = '{issueAluOp, issueDst, issueSrc1, issueSrc2, issueSrc1Valid, issueSrc2Valid,
                issueImm, issueImmValid, issueRegWrite, issueMemRead, issueMemWrite,
                issueMask};
        for (int k = 0; k < `NUM_WARPS; k++) begin
            if (eIssue[k] && issueValid) begin
                expectEq("issueWarpId", 64'(k), 64'(issueWarpId));
                expectEq("issue fields", 64'(mEnt[k][0]), 64'(act));
            end
            if (eExit[k] && exitValid)
                expectEq("exitWarpId", 64'(k), 64'(exitWarpId));
            // no fetch once full or exited
            if (mExited[k] || mCnt[k] >= `IB_DEPTH)
                expectEq($sformatf("fetchReq[%0d]", k), 64'h0, 64'(fetchReq[k]));
        end
        if (issueValid)
            obsWarps.push_back(int'(issueWarpId));
        if (exitValid)
            obsExit[exitWarpId] = 1'b1;
        // memory heads get their feedback on the next cycle
        fbPending = issueValid && (issueMemRead || issueMemWrite);
        fbWarp = issueWarpId;
        for (int k = 0; k < `NUM_WARPS; k++) begin
            if (eExit[k] || dropInstr[k]) begin
                mCnt[k] = 0;
                mWait[k] = 0;
                if (eExit[k])
                    mExited[k] = 1;
            end else if (!mExited[k]) begin
                popIt = 0;
                if (mWait[k] && zeroFbValid && int'(zeroFbWarpId) == k) begin
                    popIt = 1;
                    mWait[k] = 0;
                end else if (mWait[k] && posFbValid && int'(posFbWarpId) == k) begin
                    mEnt[k][0].mask = posFbMask;
                    mWait[k] = 0;
                end
                hd = mEnt[k][0];
                if (eIssue[k]) begin
                    if (isMem(hd))
                        mWait[k] = 1;
                    else
                        popIt = 1;
                end
                if (popIt) begin
                    mEnt[k][0] = mEnt[k][1];
                    mCnt[k]--;
                end
                if (decValid[k]) begin
                    mEnt[k][mCnt[k]] = '{decAluOp, decDst, decSrc1, decSrc2, decSrc1Valid,
                                         decSrc2Valid, decImm, decImmValid, decRegWrite,
                                         decMemRead, decMemWrite,
                                         activeMask[k*`NUM_THREADS +: `NUM_THREADS]};
                    mCnt[k]++;
                end
            end
            if (eIssue[k])
                rrPtr = (k + 1) % `NUM_WARPS;
        end
        @(negedge clk);
        posFbValid = 1'b0;
        zeroFbValid = 1'b0;
        if (fbPending) begin
            if (fbLeft > 0) begin
                posFbValid = 1'b1;
                posFbWarpId = fbWarp;
                posFbMask = fbMaskCur;
                fbLeft--;
            end else begin
                zeroFbValid = 1'b1;
                zeroFbWarpId = fbWarp;
            end
        end
    endtask

    function automatic bit modelIdle();
        modelIdle = 1;
        for (int k = 0; k < `NUM_WARPS; k++)
            if (mCnt[k] != 0 || mWait[k])
                modelIdle = 0;
    endfunction

    task automatic runTest(input testT t);
        int w;
        aluOpT op;
        curName = t.name;
        testErrors = 0;
        obsWarps.delete();
        obsExit = '0;
        fbLeft = t.replays;
        fbMaskCur = t.fbMask;
        // load while the scoreboard holds every warp
        scbDependent = '1;
        for (int k = 0; k < t.nInst; k++) begin
            w = int'(t.warps[2*k +: 2]);
            op = aluOpT'(t.ops[4*k +: 4]);
            while (!fetchReq[w])
                stepCycle();
            decAluOp = op;
            decDst = t.rnd ? `REG_W'($urandom) : `REG_W'(k + 1);
            decSrc1 = t.rnd ? `REG_W'($urandom) : `REG_W'(k + 2);
            decSrc2 = t.rnd ? `REG_W'($urandom) : `REG_W'(k + 3);
            decSrc1Valid = 1'b1;
            decSrc2Valid = (op != LW);
            decImm = t.rnd ? `IMM_W'($urandom) : `IMM_W'(16'h100 + k);
            decImmValid = (op == LW || op == SW);
            decMemRead = (op == LW);
            decMemWrite = (op == SW);
            decRegWrite = !(op inside {SW, BEQ, BLT, EXIT, NOP});
            // each warp gets a mask of its own
            for (int j = 0; j < `NUM_WARPS; j++)
                activeMask[j*`NUM_THREADS +: `NUM_THREADS] =
                    t.rnd ? `NUM_THREADS'($urandom) : '1;
            decValid = '0;
            decValid[w] = 1'b1;
            stepCycle();
            decValid = '0;
        end
        if (t.drop != '0) begin
            dropInstr = t.drop;
            stepCycle();
            dropInstr = '0;
        end
        scbDependent = '0;
        scbFull = t.hold;
        repeat (t.holdCyc)
            stepCycle();
        scbFull = '0;
        while (!modelIdle())
            stepCycle();
        repeat (2)
            stepCycle();
        expectEq("issue count", 64'(t.nExp), 64'(obsWarps.size()));
        for (int k = 0; k < t.nExp && k < obsWarps.size(); k++)
            expectEq($sformatf("issue %0d warp", k), 64'(t.expW[2*k +: 2]), 64'(obsWarps[k]));
        expectEq("exit warps", 64'(t.expExit), 64'(obsExit));
        if (testErrors == 0) begin
            $display("PASS %s", t.name);
            passed++;
        end else begin
            $display("FAIL %s with %0d errors", t.name, testErrors);
        end
        totalErrors += testErrors;
    endtask

    initial begin
        void'($urandom(69));
        tests[0] = '{"fourWarps", 8, 16'hE4E4, 32'h76543210, 1'b0, 4'h0, 0, 4'h0, 0, 8'h00,
                     8, 16'hE4E4, 4'h0};
        tests[1] = '{"singleWarp", 2, 16'h000A, 32'h00000070, 1'b1, 4'h0, 0, 4'h0, 0, 8'h00,
                     2, 16'h000A, 4'h0};
        tests[2] = '{"backPressure", 3, 16'h0010, 32'h00000310, 1'b1, 4'h2, 6, 4'h0, 0, 8'h00,
                     3, 16'h0010, 4'h0};
        tests[3] = '{"memReplay", 2, 16'h000F, 32'h00000008, 1'b0, 4'h0, 0, 4'h0, 1, 8'h0F,
                     3, 16'h003F, 4'h0};
        tests[4] = '{"dropExit", 3, 16'h0035, 32'h00000C10, 1'b0, 4'h0, 0, 4'h2, 0, 8'h00,
                     0, 16'h0000, 4'h8};
        limit = 100;
        for (int i = 0; i < NT; i++)
            limit += 40 * tests[i].nInst;
        cycles = 0;
        totalErrors = 0;
        passed = 0;
        rrPtr = 0;
        for (int k = 0; k < `NUM_WARPS; k++) begin
            mCnt[k] = 0;
            mWait[k] = 0;
            mExited[k] = 0;
        end
        rstN = 1'b0;
        decAluOp = NOP;
        {decDst, decSrc1, decSrc2, decImm} = '0;
        {decSrc1Valid, decSrc2Valid, decImmValid, decRegWrite, decMemRead, decMemWrite} = '0;
        decValid = '0;
        dropInstr = '0;
        scbFull = '0;
        scbDependent = '1;
        activeMask = '0;
        {posFbValid, zeroFbValid, posFbWarpId, zeroFbWarpId, posFbMask} = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // idle outputs right after reset
        curName = "afterReset";
        testErrors = 0;
        repeat (3) begin
            expectEq("fetchReq", 64'hF, 64'(fetchReq));
            expectEq("issueValid", 64'h0, 64'(issueValid));
            expectEq("exitValid", 64'h0, 64'(exitValid));
            stepCycle();
        end
        if (testErrors == 0)
            passed++;
        $display("%s %s", testErrors == 0 ? "PASS" : "FAIL", curName);
        totalErrors += testErrors;

        for (int i = 0; i < NT; i++)
            runTest(tests[i]);

        $display("tests %0d, passed %0d, errors %0d", NT + 1, passed, totalErrors);
        if (totalErrors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
gpuIssuePkg.sv
warpInstBuffer.sv
instBuffer.sv
issueArbiter.sv
issueStage.sv
issueStage_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = issueStage_tb
FILELIST  = filelist.f
PASS_MSG  = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(shell grep -v '^+' $(FILELIST)) gpuIssue_consts.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
